// ==== design/dma_pkg.sv ====
// Shared widths and encodings for the systolic-array DMA engine
// Addresses are 32-bit byte addresses and every row is one SA_WIDTH-beat burst
// SA_WIDTH must be a power of two so that the beat and row counters wrap cleanly
package dma_pkg;

    localparam int DW       = 32;
    localparam int SA_WIDTH = 4;
    localparam int BUF_AW   = 6;
    localparam int BUF_DW   = SA_WIDTH * DW;
    localparam int ACC_W    = 2 * DW + 1;

    // Beat and row counter width, and the index of the final beat or row
    localparam int CNT_W = $clog2(SA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(SA_WIDTH - 1);

    // Fixed AXI burst fields: one INCR burst of 4-byte beats per row
    localparam int AXI_LEN   = SA_WIDTH - 1;
    localparam int AXI_SIZE  = $clog2(DW / 8);
    localparam int AXI_INCR  = 1;
    localparam int ROW_BYTES = (AXI_LEN + 1) * (1 << AXI_SIZE);

    typedef enum logic [2:0] {
        IDLE,
        READ_A,
        READ_B,
        START_MM,
        WAIT_MM,
        WRITE_C,
        WAIT_B,
        DONE
    } dma_state_e;

    // Tells the data paths which transfer owns the counters
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_RD_A,
        PH_RD_B,
        PH_WR_C
    } dma_phase_e;

endpackage

// ==== design/dma_xfer_if.sv ====
// Internal handshake between the DMA state machine, counter and data paths
// All signals are synchronous to the engine clock; pulses last one cycle
`timescale 1ns/1ps

interface dma_xfer_if;

    dma_pkg::dma_phase_e         phase;
    logic                        clr;
    logic                        row_adv;
    logic                        rd_beat;
    logic                        wr_beat;
    logic [dma_pkg::CNT_W-1:0]   beat_idx;
    logic [dma_pkg::CNT_W-1:0]   row_idx;
    logic                        last_beat;
    logic                        last_row;

    modport fsm (
        output phase, clr, row_adv,
        input  rd_beat, wr_beat, row_idx, last_beat, last_row
    );

    modport cnt (
        input  clr, row_adv, rd_beat, wr_beat,
        output beat_idx, row_idx, last_beat, last_row
    );

    modport rd (
        input  phase, beat_idx, row_idx,
        output rd_beat
    );

    modport wr (
        input  phase, beat_idx, row_idx, last_beat,
        output wr_beat
    );

endinterface

// ==== design/dma_ctrl_fsm.sv ====
// Sequencer for load A, load B, multiply handoff and writeback of C
// Base addresses must stay stable from start_i until done_o
// One AXI burst is outstanding at a time
`timescale 1ns/1ps

module dma_ctrl_fsm (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  logic [31:0] mat_a_addr_i,
    input  logic [31:0] mat_b_addr_i,
    input  logic [31:0] mat_c_addr_i,
    input  logic        mm_done_i,
    input  logic        arready_i,
    input  logic        awready_i,
    input  logic        bvalid_i,
    output logic        mm_start_o,
    output logic        done_o,
    output logic        arvalid_o,
    output logic [31:0] araddr_o,
    output logic        awvalid_o,
    output logic [31:0] awaddr_o,
    output logic        bready_o,
    dma_xfer_if.fsm     xfer
);

    dma_pkg::dma_state_e state_q;
    dma_pkg::dma_phase_e phase_q;
    logic                ar_pend_q;
    logic                rd_last;
    logic                b_ok;

    function automatic logic [31:0] row_addr(input logic [31:0]             base,
                                             input logic [dma_pkg::CNT_W:0] row);
        row_addr = base + 32'(row) * dma_pkg::ROW_BYTES;
    endfunction

    assign rd_last  = xfer.rd_beat && xfer.last_beat;
    assign bready_o = (state_q == dma_pkg::WAIT_B);
    assign b_ok     = bvalid_i && bready_o;
    assign done_o   = (state_q == dma_pkg::DONE);

    assign xfer.phase   = phase_q;
    assign xfer.row_adv = rd_last || b_ok;
    // Counters restart for each matrix
    assign xfer.clr = (state_q == dma_pkg::IDLE && start_i) ||
                      (state_q == dma_pkg::READ_A && rd_last && xfer.last_row) ||
                      (state_q == dma_pkg::WAIT_MM && mm_done_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= dma_pkg::IDLE;
            phase_q    <= dma_pkg::PH_IDLE;
            ar_pend_q  <= 1'b0;
            arvalid_o  <= 1'b0;
            awvalid_o  <= 1'b0;
            mm_start_o <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            if (arvalid_o && arready_i) begin
                arvalid_o <= 1'b0;
            end
            // W beats may only start once the write address is taken
            if (awvalid_o && awready_i) begin
                awvalid_o <= 1'b0;
                phase_q   <= dma_pkg::PH_WR_C;
            end
            // Next read request goes out the cycle after the buffer write
            if (ar_pend_q) begin
                arvalid_o <= 1'b1;
                ar_pend_q <= 1'b0;
            end
            case (state_q)
                dma_pkg::IDLE: begin
                    if (start_i) begin
                        state_q   <= dma_pkg::READ_A;
                        phase_q   <= dma_pkg::PH_RD_A;
                        arvalid_o <= 1'b1;
                    end
                end
                dma_pkg::READ_A: begin
                    if (rd_last) begin
                        ar_pend_q <= 1'b1;
                        if (xfer.last_row) begin
                            state_q <= dma_pkg::READ_B;
                            phase_q <= dma_pkg::PH_RD_B;
                        end
                    end
                end
                dma_pkg::READ_B: begin
                    if (rd_last) begin
                        if (xfer.last_row) begin
                            state_q <= dma_pkg::START_MM;
                            phase_q <= dma_pkg::PH_IDLE;
                        end else begin
                            ar_pend_q <= 1'b1;
                        end
                    end
                end
                dma_pkg::START_MM: begin
                    mm_start_o <= 1'b1;
                    state_q    <= dma_pkg::WAIT_MM;
                end
                dma_pkg::WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q   <= dma_pkg::WRITE_C;
                        awvalid_o <= 1'b1;
                    end
                end
                dma_pkg::WRITE_C: begin
                    if (xfer.wr_beat && xfer.last_beat) begin
                        state_q <= dma_pkg::WAIT_B;
                        phase_q <= dma_pkg::PH_IDLE;
                    end
                end
                dma_pkg::WAIT_B: begin
                    if (bvalid_i) begin
                        if (xfer.last_row) begin
                            state_q <= dma_pkg::DONE;
                        end else begin
                            state_q   <= dma_pkg::WRITE_C;
                            awvalid_o <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= dma_pkg::IDLE;
                end
            endcase
        end
    end

    // Burst addresses, loaded together with the matching valid
    always_ff @(posedge clk) begin
        if (state_q == dma_pkg::IDLE && start_i) begin
            araddr_o <= mat_a_addr_i;
        end else if (ar_pend_q) begin
            araddr_o <= row_addr((phase_q == dma_pkg::PH_RD_B) ? mat_b_addr_i : mat_a_addr_i,
                                 {1'b0, xfer.row_idx});
        end
        if (state_q == dma_pkg::WAIT_MM && mm_done_i) begin
            awaddr_o <= mat_c_addr_i;
        end else if (b_ok && !xfer.last_row) begin
            // Row counter advances on this same edge
            awaddr_o <= row_addr(mat_c_addr_i, {1'b0, xfer.row_idx} + 1'b1);
        end
    end

    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

    mm_start_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_o |=> !mm_start_o);

endmodule

// ==== design/dma_beat_counter.sv ====
// Beat-within-burst and row-within-matrix counters shared by both data paths
// Both counts wrap at SA_WIDTH; clr has priority over any advance
`timescale 1ns/1ps

module dma_beat_counter (
    input  logic    clk,
    input  logic    rst_n,
    dma_xfer_if.cnt xfer
);

    logic [dma_pkg::CNT_W-1:0] beat_q;
    logic [dma_pkg::CNT_W-1:0] row_q;

    assign xfer.beat_idx  = beat_q;
    assign xfer.row_idx   = row_q;
    assign xfer.last_beat = (beat_q == dma_pkg::LAST_IDX);
    assign xfer.last_row  = (row_q == dma_pkg::LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
            row_q  <= '0;
        end else if (xfer.clr) begin
            beat_q <= '0;
            row_q  <= '0;
        end else begin
            // Only one data path is active at a time
            if (xfer.rd_beat || xfer.wr_beat) begin
                beat_q <= xfer.last_beat ? '0 : beat_q + 1'b1;
            end
            if (xfer.row_adv) begin
                row_q <= xfer.last_row ? '0 : row_q + 1'b1;
            end
        end
    end

    // A read and a write burst must never overlap
    beat_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(xfer.rd_beat && xfer.wr_beat));

endmodule

// ==== design/dma_rd_pack.sv ====
// Packs SA_WIDTH read beats into one buffer line, beat 0 in the low bits
// Buffers A and B share address and data; only the wren selects the target
// Line data is valid only in the cycle where a wren is high
`timescale 1ns/1ps

module dma_rd_pack (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rvalid_i,
    input  logic [dma_pkg::DW-1:0]      rdata_i,
    input  logic                        rlast_i,
    output logic                        rready_o,
    output logic                        buf_a_wren_o,
    output logic                        buf_b_wren_o,
    output logic [dma_pkg::BUF_AW-1:0]  buf_waddr_o,
    output logic [dma_pkg::BUF_DW-1:0]  buf_wdata_o,
    dma_xfer_if.rd                      xfer
);

    logic [dma_pkg::BUF_DW-1:0] line_q;
    logic                       line_done;

    // Always ready while a read phase is active
    assign rready_o = (xfer.phase == dma_pkg::PH_RD_A) || (xfer.phase == dma_pkg::PH_RD_B);

    assign xfer.rd_beat = rvalid_i && rready_o;
    assign line_done    = xfer.rd_beat && rlast_i;
    assign buf_wdata_o  = line_q;

    always_ff @(posedge clk) begin
        if (xfer.rd_beat) begin
            line_q[xfer.beat_idx * dma_pkg::DW +: dma_pkg::DW] <= rdata_i;
        end
        if (line_done) begin
            buf_waddr_o <= {{(dma_pkg::BUF_AW - dma_pkg::CNT_W){1'b0}}, xfer.row_idx};
        end
    end

    // Write strobe follows the final beat by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
        end else begin
            buf_a_wren_o <= line_done && (xfer.phase == dma_pkg::PH_RD_A);
            buf_b_wren_o <= line_done && (xfer.phase == dma_pkg::PH_RD_B);
        end
    end

    // Memory burst length must agree with the local beat count
    rlast_align_a: assert property (@(posedge clk) disable iff (!rst_n)
        xfer.rd_beat |-> (rlast_i == (xfer.beat_idx == dma_pkg::LAST_IDX)));

endmodule

// ==== design/dma_wr_stream.sv ====
// Streams one row of C as SA_WIDTH write beats, low DW bits of each accumulator
// accum_i must hold steady for the whole writeback
`timescale 1ns/1ps

module dma_wr_stream (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wready_i,
    input  logic signed [dma_pkg::ACC_W-1:0] accum_i [dma_pkg::SA_WIDTH][dma_pkg::SA_WIDTH],
    output logic                            wvalid_o,
    output logic [dma_pkg::DW-1:0]          wdata_o,
    output logic                            wlast_o,
    dma_xfer_if.wr                          xfer
);

    logic wvalid_q;

    assign wvalid_o     = wvalid_q;
    assign xfer.wr_beat = wvalid_q && wready_i;
    assign wlast_o      = wvalid_q && xfer.last_beat;

    // Counters only move on an accepted beat, so data holds under back-pressure
    assign wdata_o = accum_i[xfer.row_idx][xfer.beat_idx][dma_pkg::DW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid_q <= 1'b0;
        end else if (xfer.wr_beat && xfer.last_beat) begin
            wvalid_q <= 1'b0;
        end else if (xfer.phase == dma_pkg::PH_WR_C) begin
            // Phase turns on only after the write address is accepted
            wvalid_q <= 1'b1;
        end
    end

    w_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wlast_o));

endmodule

// ==== design/dma_engine.sv ====
// DMA engine for a 4x4 systolic-array multiplier, simplified AXI master
// Burst length, size and type are fixed (4 beats, 4 bytes, INCR) and not driven
// No IDs, response codes or error handling
`timescale 1ns/1ps

module dma_engine (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [31:0]                      mat_a_addr_i,
    input  logic [31:0]                      mat_b_addr_i,
    input  logic [31:0]                      mat_c_addr_i,
    input  logic                             start_i,
    output logic                             done_o,
    // Multiply engine handoff
    output logic                             mm_start_o,
    input  logic                             mm_done_i,
    input  logic signed [dma_pkg::ACC_W-1:0] accum_i [dma_pkg::SA_WIDTH][dma_pkg::SA_WIDTH],
    // AXI read address and data
    output logic                             arvalid_o,
    input  logic                             arready_i,
    output logic [31:0]                      araddr_o,
    input  logic                             rvalid_i,
    output logic                             rready_o,
    input  logic [dma_pkg::DW-1:0]           rdata_i,
    input  logic                             rlast_i,
    // AXI write address, data and response
    output logic                             awvalid_o,
    input  logic                             awready_i,
    output logic [31:0]                      awaddr_o,
    output logic                             wvalid_o,
    input  logic                             wready_i,
    output logic [dma_pkg::DW-1:0]           wdata_o,
    output logic                             wlast_o,
    input  logic                             bvalid_i,
    output logic                             bready_o,
    // Buffer A and B write ports
    output logic                             buf_a_wren_o,
    output logic                             buf_b_wren_o,
    output logic [dma_pkg::BUF_AW-1:0]       buf_waddr_o,
    output logic [dma_pkg::BUF_DW-1:0]       buf_wdata_o
);

    dma_xfer_if u_xfer ();

    dma_ctrl_fsm u_fsm (
        .xfer (u_xfer),
        .*
    );

    dma_beat_counter u_cnt (
        .xfer (u_xfer),
        .*
    );

    dma_rd_pack u_rd (
        .xfer (u_xfer),
        .*
    );

    dma_wr_stream u_wr (
        .xfer (u_xfer),
        .*
    );

endmodule

// ==== dv/tb_axi_mem.sv ====
// Behavioral AXI slave for the DMA testbench, one read and one write burst at a time
// Ready and valid stalls follow the go_i bits that the testbench randomizes each cycle
// Unloaded addresses return a pattern built from the address
`timescale 1ns/1ps

module tb_axi_mem (
    input  logic        clk,
    input  logic [4:0]  go_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [31:0] araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o,
    output logic        rlast_o,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    input  logic        wlast_i,
    output logic        bvalid_o,
    input  logic        bready_i
);

    logic [31:0] mem [logic [31:0]];
    logic [31:0] ar_log [$];
    logic [31:0] aw_log [$];
    int          wlast_bad;
    logic [31:0] rd_addr, wr_addr, ar_a, aw_a, w_d;
    logic        rd_busy, wr_busy, b_pend, w_l;
    logic        ar_f, r_f, aw_f, w_f, b_f;
    int          rd_cnt, wr_cnt;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        read_word = mem.exists(addr) ? mem[addr] : (addr ^ 32'hdead_beef);
    endfunction

    initial begin
        {arready_o, rvalid_o, rlast_o, awready_o, wready_o, bvalid_o} = '0;
        rdata_o   = '0;
        {rd_busy, wr_busy, b_pend} = '0;
        {rd_addr, wr_addr} = '0;
        rd_cnt    = 0;
        wr_cnt    = 0;
        wlast_bad = 0;
        forever begin
            // Handshakes are sampled mid-cycle and take effect at the next edge
            @(negedge clk);
            ar_f = arvalid_i && arready_o;
            r_f  = rvalid_o && rready_i;
            aw_f = awvalid_i && awready_o;
            w_f  = wvalid_i && wready_o;
            b_f  = bvalid_o && bready_i;
            ar_a = araddr_i;
            aw_a = awaddr_i;
            w_d  = wdata_i;
            w_l  = wlast_i;
            @(posedge clk);
            #2;
            if (ar_f) begin
                ar_log.push_back(ar_a);
                rd_addr = ar_a;
                rd_busy = 1'b1;
                rd_cnt  = 0;
            end
            if (r_f) begin
                rd_cnt++;
                if (rd_cnt == 4) rd_busy = 1'b0;
            end
            if (aw_f) begin
                aw_log.push_back(aw_a);
                wr_addr = aw_a;
                wr_busy = 1'b1;
                wr_cnt  = 0;
            end
            if (w_f) begin
                mem[wr_addr + 32'(4 * wr_cnt)] = w_d;
                if (w_l != (wr_cnt == 3)) wlast_bad++;
                wr_cnt++;
                if (wr_cnt == 4) b_pend = 1'b1;
            end
            if (b_f) begin
                b_pend  = 1'b0;
                wr_busy = 1'b0;
            end
            arready_o = !rd_busy && go_i[0];
            rvalid_o  = rd_busy && ((rvalid_o && !r_f) || go_i[1]);
            rdata_o   = read_word(rd_addr + 32'(4 * rd_cnt));
            rlast_o   = (rd_cnt == 3);
            awready_o = !wr_busy && go_i[2];
            wready_o  = wr_busy && !b_pend && go_i[3];
            bvalid_o  = b_pend && ((bvalid_o && !b_f) || go_i[4]);
        end
    end

endmodule

// ==== dv/tb_dma_engine.sv ====
// Testbench for dma_engine; stimulus and expected values come from dv/dma_golden.txt
// The testbench stands in for the multiply engine and both buffers
// Runs from the project root so that the golden file path resolves
`timescale 1ns/1ps

module tb_dma_engine;

    logic clk, rst_n, start_i, done_o, mm_start_o, mm_done_i;
    logic [31:0] mat_a_addr_i, mat_b_addr_i, mat_c_addr_i, araddr_o, awaddr_o;
    logic signed [dma_pkg::ACC_W-1:0] accum_i [dma_pkg::SA_WIDTH][dma_pkg::SA_WIDTH];
    logic arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;
    logic awvalid_o, awready_i, wvalid_o, wready_i, wlast_o, bvalid_i, bready_o;
    logic [dma_pkg::DW-1:0]     rdata_i, wdata_o;
    logic                       buf_a_wren_o, buf_b_wren_o;
    logic [dma_pkg::BUF_AW-1:0] buf_waddr_o;
    logic [dma_pkg::BUF_DW-1:0] buf_wdata_o;
    logic [dma_pkg::BUF_DW-1:0] got_a [4];
    logic [dma_pkg::BUF_DW-1:0] got_b [4];
    logic [31:0] rnd;
    logic [4:0]  go;
    logic [1:0]  stall;
    int fd, rc, n_tests, errors, checks, a_cnt, b_cnt, mm_cnt, done_cnt, resp_cnt;
    logic mm_seen;
    string hdr;

    dma_engine u_dut (.*);

    tb_axi_mem u_mem (
        .clk(clk), .go_i(go),
        .arvalid_i(arvalid_o), .arready_o(arready_i), .araddr_i(araddr_o),
        .rvalid_o(rvalid_i), .rready_i(rready_o), .rdata_o(rdata_i), .rlast_o(rlast_i),
        .awvalid_i(awvalid_o), .awready_o(awready_i), .awaddr_i(awaddr_o),
        .wvalid_i(wvalid_o), .wready_o(wready_i), .wdata_i(wdata_o), .wlast_i(wlast_o),
        .bvalid_o(bvalid_i), .bready_i(bready_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        xorshift32 = y ^ (y << 5);
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("Failure: %s", what);
    endtask

    task automatic check_line(input string name, input logic [dma_pkg::BUF_DW-1:0] got,
                              input logic [dma_pkg::BUF_DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [dma_pkg::DW-1:0] got,
                              input logic [dma_pkg::DW-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Stall pattern for the memory, refreshed mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            rnd = xorshift32(rnd);
            for (int k = 0; k < 5; k++) go[k] = (rnd[2*k +: 2] >= stall);
        end
    end

    // Buffer and handoff monitor
    initial begin
        forever begin
            @(negedge clk);
            if (buf_a_wren_o) begin
                if (b_cnt != 0 || a_cnt > 3) report_failure("buffer A written out of order");
                else got_a[a_cnt] = buf_wdata_o;
                check_addr("buf_waddr_o", 32'(buf_waddr_o), 32'(a_cnt));
                a_cnt++;
            end
            if (buf_b_wren_o) begin
                if (a_cnt != 4 || b_cnt > 3) report_failure("buffer B written out of order");
                else got_b[b_cnt] = buf_wdata_o;
                check_addr("buf_waddr_o", 32'(buf_waddr_o), 32'(b_cnt));
                b_cnt++;
            end
            if (mm_start_o) begin
                if (b_cnt != 4) report_failure("multiply started before buffer B was full");
                mm_cnt++;
            end
            if (awvalid_o && !mm_seen) report_failure("write address issued before multiply done");
            if (mm_done_i) mm_seen = 1'b1;
            if (bvalid_i && bready_o) resp_cnt++;
            if (done_o) begin
                if (resp_cnt != 4) report_failure("done_o pulsed before the fourth write response");
                done_cnt++;
            end
        end
    end

    // Multiply engine stand-in with a random latency
    initial begin
        forever begin
            @(negedge clk);
            if (mm_start_o) begin
                @(posedge clk);
                repeat (int'(rnd[7:4])) @(posedge clk);
                #2 mm_done_i = 1'b1;
                @(posedge clk);
                #2 mm_done_i = 1'b0;
            end
        end
    end

    task automatic run_test(input int t);
        logic [31:0] w;
        logic [dma_pkg::ACC_W-1:0] acc;
        logic [dma_pkg::BUF_DW-1:0] exp_l;
        int err0;
        err0 = errors;
        rc = $fscanf(fd, "%h %h %h %h", stall, mat_a_addr_i, mat_b_addr_i, mat_c_addr_i);
        if (rc != 4) report_failure("golden file ended before a test header");
        for (int k = 0; k < 32; k++) begin
            rc = $fscanf(fd, "%h", w);
            u_mem.mem[(k < 16 ? mat_a_addr_i : mat_b_addr_i) + 32'(4 * (k % 16))] = w;
        end
        for (int k = 0; k < 16; k++) begin
            rc = $fscanf(fd, "%h", acc);
            accum_i[k / 4][k % 4] = acc;
        end
        {a_cnt, b_cnt, mm_cnt, done_cnt, resp_cnt} = '0;
        mm_seen = 1'b0;
        u_mem.ar_log.delete();
        u_mem.aw_log.delete();
        u_mem.wlast_bad = 0;
        start_i = 1'b1;
        @(posedge clk);
        #2 start_i = 1'b0;
        while (done_cnt == 0) @(posedge clk);
        repeat (10) @(posedge clk);
        #2;
        for (int r = 0; r < 8; r++) begin
            rc = $fscanf(fd, "%h", exp_l);
            check_line($sformatf("buf_%s line %0d", r < 4 ? "a" : "b", r % 4),
                       r < 4 ? got_a[r] : got_b[r - 4], exp_l);
        end
        for (int k = 0; k < 16; k++) begin
            rc = $fscanf(fd, "%h", w);
            check_word($sformatf("c[%0d][%0d]", k / 4, k % 4),
                       u_mem.read_word(mat_c_addr_i + 32'(16 * (k / 4) + 4 * (k % 4))), w);
        end
        if (u_mem.ar_log.size() != 8) report_failure("wrong number of read bursts");
        else for (int r = 0; r < 8; r++)
            check_addr("araddr_o", u_mem.ar_log[r],
                       (r < 4 ? mat_a_addr_i : mat_b_addr_i) + 32'(16 * (r % 4)));
        if (u_mem.aw_log.size() != 4) report_failure("wrong number of write bursts");
        else for (int r = 0; r < 4; r++)
            check_addr("awaddr_o", u_mem.aw_log[r], mat_c_addr_i + 32'(16 * r));
        if (mm_cnt != 1) report_failure("mm_start_o did not pulse exactly once");
        if (done_cnt != 1) report_failure("done_o did not pulse exactly once");
        if (u_mem.wlast_bad != 0) report_failure("wlast not on the fourth beat of a burst");
        $display("test %0d (stall level %0d): %0d errors", t, stall, errors - err0);
    endtask

    initial begin
        {rst_n, start_i, mm_done_i} = '0;
        {mat_a_addr_i, mat_b_addr_i, mat_c_addr_i} = '0;
        foreach (accum_i[i, j]) accum_i[i][j] = '0;
        rnd     = 32'hebaf_b695;
        go      = '0;
        stall   = '0;
        {n_tests, errors, checks, a_cnt, b_cnt, mm_cnt, done_cnt, resp_cnt} = '0;
        mm_seen = 1'b0;
        fd = $fopen("dv/dma_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open dv/dma_golden.txt");
            $display("Test failed");
            $finish;
        end else begin
            rc = $fgets(hdr, fd);
            rc = $fgets(hdr, fd);
            rc = $fscanf(fd, "%d", n_tests);
            if (rc != 1 || n_tests <= 0) report_failure("golden file holds no tests");
            repeat (8) @(posedge clk);
            #2 rst_n = 1'b1;
            repeat (2) @(posedge clk);
            #2;
            for (int t = 0; t < n_tests; t++) run_test(t);
            $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
            if (errors == 0) $display("Test passed");
            else $display("Test failed");
            $finish;
        end
    end

    // Watchdog sized at 400 cycles per test
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 400 + 20) @(posedge clk);
        $display("Timeout: DUT did not finish all tests in time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== dv/dma_golden.txt ====
# test count; per test: stall a_addr b_addr c_addr, 32 words (A then B), 16 accumulators
# (row major), 8 expected buffer lines (A rows then B rows), 16 expected C words
2
0 00001000 00002000 00003000
a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
a0000008 a0000009 a000000a a000000b a000000c a000000d a000000e a000000f
b0000000 b0000001 b0000002 b0000003 b0000004 b0000005 b0000006 b0000007
b0000008 b0000009 b000000a b000000b b000000c b000000d b000000e b000000f
c0000000 c0000001 c0000002 c0000003 c0000004 1ffffffffffffffff c0000006 c0000007
c0000008 c0000009 123456789abcdef01 c000000b c000000c c000000d c000000e c000000f
a0000003a0000002a0000001a0000000 a0000007a0000006a0000005a0000004
a000000ba000000aa0000009a0000008 a000000fa000000ea000000da000000c
b0000003b0000002b0000001b0000000 b0000007b0000006b0000005b0000004
b000000bb000000ab0000009b0000008 b000000fb000000eb000000db000000c
c0000000 c0000001 c0000002 c0000003 c0000004 ffffffff c0000006 c0000007
c0000008 c0000009 abcdef01 c000000b c000000c c000000d c000000e c000000f
3 00010040 00020080 000300c0
5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0004 5a5a0005 5a5a0006 5a5a0007
5a5a0008 5a5a0009 5a5a000a 5a5a000b 5a5a000c 5a5a000d 5a5a000e 5a5a000f
6b6b0000 6b6b0001 6b6b0002 6b6b0003 6b6b0004 6b6b0005 6b6b0006 6b6b0007
6b6b0008 6b6b0009 6b6b000a 6b6b000b 6b6b000c 6b6b000d 6b6b000e 6b6b000f
1fffffffffffffff0 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007
d0000008 d0000009 d000000a d000000b d000000c d000000d d000000e d000000f
5a5a00035a5a00025a5a00015a5a0000 5a5a00075a5a00065a5a00055a5a0004
5a5a000b5a5a000a5a5a00095a5a0008 5a5a000f5a5a000e5a5a000d5a5a000c
6b6b00036b6b00026b6b00016b6b0000 6b6b00076b6b00066b6b00056b6b0004
6b6b000b6b6b000a6b6b00096b6b0008 6b6b000f6b6b000e6b6b000d6b6b000c
fffffff0 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007
d0000008 d0000009 d000000a d000000b d000000c d000000d d000000e d000000f

// ==== src.f ====
design/dma_pkg.sv
design/dma_xfer_if.sv
design/dma_ctrl_fsm.sv
design/dma_beat_counter.sv
design/dma_rd_pack.sv
design/dma_wr_stream.sv
design/dma_engine.sv
dv/tb_axi_mem.sv
dv/tb_dma_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_dma_engine
FILELIST  := src.f
SRCS      := $(shell cat $(FILELIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
